// File: fdc_pkg.sv
/*
 * floppy disk controller shared definitions
 * register map, command kinds, timing constants and disk geometry
 */
package fdc_pkg;

	// ==================================================
	// host register map
	// ==================================================

	localparam logic [1:0] A_STATUS  = 2'd0; // read side of address 0
	localparam logic [1:0] A_COMMAND = 2'd0; // write side of address 0
	localparam logic [1:0] A_TRACK   = 2'd1;
	localparam logic [1:0] A_SECTOR  = 2'd2;
	localparam logic [1:0] A_DATA    = 2'd3;

	// command kinds after decode of the top nibble
	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_RESTORE,
		CMD_SEEK,
		CMD_STEP,
		CMD_STEP_IN,
		CMD_STEP_OUT,
		CMD_READ,
		CMD_ABORT
	} cmd_kind_t;

	// ==================================================
	// timing, in clk_sys cycles
	// ==================================================

	localparam logic [7:0] SETTLE_CYCLES   = 8'd64;   // busy time of positioning commands
	localparam logic [5:0] SEARCH_CYCLES   = 6'd32;   // delay before the sector check
	localparam logic [3:0] BYTE_GAP_CYCLES = 4'd8;    // pause after a byte is taken
	localparam logic [9:0] LOST_CYCLES     = 10'd512; // drq watchdog

	// ==================================================
	// disk image geometry
	// ==================================================

	localparam int IMG_AW = 20; // 1 MiB image

	// indexed by size_code 0..5
	localparam logic [0:5][7:0] GEOM_SPT = {
		8'd26, 8'd16, 8'd9, 8'd5, 8'd10, 8'd18
	};

	// sector size is 128 << code
	localparam logic [0:5][1:0] GEOM_SIZE_CODE = {
		2'd0, 2'd1, 2'd2, 2'd3, 2'd2, 2'd1
	};

endpackage

// File: fdc_cmd_decode.sv
/*
 * host register decode
 * splits bus strobes by address, classifies commands, holds the
 * data register and drives the readback mux
 */
`timescale 1ns/1ns

module fdc_cmd_decode import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       rd,
	input  logic       wr,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	input  logic       busy,
	input  logic [7:0] status_byte,
	input  logic [7:0] track_reg,
	input  logic [7:0] sector_reg,
	input  logic [7:0] xfer_byte,
	input  logic       xfer_active,
	output logic [7:0] dout,
	output logic       cmd_valid,
	output cmd_kind_t  cmd_kind,
	output logic       cmd_flag_u,
	output logic       cmd_hld,
	output logic       cmd_dir,
	output logic       track_wr,
	output logic       sector_wr,
	output logic [7:0] wr_byte,
	output logic [7:0] data_reg,
	output logic       data_taken,
	output logic       status_taken
);

	logic is_abort;

	assign is_abort = (din[7:4] == 4'hD); // force interrupt gets through while busy

	// ==================================================
	// write side
	// ==================================================

	always_comb begin
		case (din[7:4])
			4'h0:       cmd_kind = CMD_RESTORE;
			4'h1:       cmd_kind = CMD_SEEK;
			4'h2, 4'h3: cmd_kind = CMD_STEP;
			4'h4, 4'h5: cmd_kind = CMD_STEP_IN;
			4'h6, 4'h7: cmd_kind = CMD_STEP_OUT;
			4'h8, 4'h9: cmd_kind = CMD_READ;
			4'hD:       cmd_kind = CMD_ABORT;
			default:    cmd_kind = CMD_NONE; // write and track ops are no-ops
		endcase
	end

	assign cmd_valid  = wr && (addr == A_COMMAND) && (!busy || is_abort);
	assign cmd_flag_u = din[4]; // track update or multi-sector read
	assign cmd_hld    = din[3];
	assign cmd_dir    = din[5];

	assign track_wr  = wr && (addr == A_TRACK) && !busy;
	assign sector_wr = wr && (addr == A_SECTOR) && !busy;
	assign wr_byte   = din;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			data_reg <= 8'd0;
		else if (wr && (addr == A_DATA))
			data_reg <= din;
	end

	// ==================================================
	// read side
	// ==================================================

	assign data_taken   = rd && (addr == A_DATA);
	assign status_taken = rd && (addr == A_STATUS);

	always_comb begin
		case (addr)
			A_STATUS: dout = status_byte;
			A_TRACK:  dout = track_reg;
			A_SECTOR: dout = sector_reg;
			default:  dout = xfer_active ? xfer_byte : data_reg;
		endcase
	end

endmodule

// File: fdc_head_ctrl.sv
/*
 * head positioning
 * keeps the physical head track, the track register and the last
 * step direction, and holds seek_busy for the settle time
 */
`timescale 1ns/1ns

module fdc_head_ctrl import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       cmd_valid,
	input  cmd_kind_t  cmd_kind,
	input  logic       cmd_flag_u,
	input  logic       cmd_dir,
	input  logic [7:0] data_reg,
	input  logic       track_wr,
	input  logic [7:0] wr_byte,
	output logic [7:0] disk_track,
	output logic [7:0] track_reg,
	output logic       seek_busy,
	output logic       seek_done
);

	logic       step_dir;   // 1 = out, towards track 0
	logic       step_out;
	logic [7:0] next_track;
	logic [7:0] settle_cnt;
	logic       is_pos;

	assign is_pos = cmd_kind inside {CMD_RESTORE, CMD_SEEK, CMD_STEP,
		CMD_STEP_IN, CMD_STEP_OUT};

	// plain step reuses the remembered direction
	always_comb begin
		step_out = step_dir;
		if (cmd_kind == CMD_STEP_IN || cmd_kind == CMD_STEP_OUT)
			step_out = cmd_dir;
		if (step_out)
			next_track = (disk_track == 8'd0) ? 8'd0 : disk_track - 8'd1; // track 0 stop
		else
			next_track = disk_track + 8'd1;
	end

	assign seek_done = seek_busy && (settle_cnt == 8'd0); // same cycle busy drops

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			disk_track <= 8'd0;
			track_reg  <= 8'd0;
			step_dir   <= 1'b0;
			seek_busy  <= 1'b0;
			settle_cnt <= 8'd0;
		end else if (cmd_valid && cmd_kind == CMD_ABORT) begin
			seek_busy  <= 1'b0;
			settle_cnt <= 8'd0;
		end else if (cmd_valid && is_pos) begin
			seek_busy  <= 1'b1;
			settle_cnt <= SETTLE_CYCLES - 8'd1;
			case (cmd_kind)
				CMD_RESTORE: begin
					disk_track <= 8'd0;
					track_reg  <= 8'd0;
				end
				CMD_SEEK: begin
					disk_track <= data_reg; // target comes from the data register
					track_reg  <= data_reg;
				end
				default: begin
					disk_track <= next_track;
					if (cmd_flag_u)
						track_reg <= next_track;
					if (cmd_kind != CMD_STEP)
						step_dir <= cmd_dir;
				end
			endcase
		end else begin
			if (track_wr)
				track_reg <= wr_byte;
			if (seek_done)
				seek_busy <= 1'b0;
			else if (seek_busy)
				settle_cnt <= settle_cnt - 8'd1;
		end
	end

endmodule

// File: fdc_sector_read.sv
/*
 * sector read engine
 * checks the requested sector, fetches bytes from the image RAM,
 * runs DRQ with the lost-data watchdog and walks multi-sector reads
 */
`timescale 1ns/1ns

module fdc_sector_read import fdc_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              cmd_valid,
	input  cmd_kind_t         cmd_kind,
	input  logic              cmd_flag_u,
	input  logic [7:0]        disk_track,
	input  logic              side,
	input  logic [2:0]        size_code,
	input  logic              drive_ready,
	input  logic              sector_wr,
	input  logic [7:0]        wr_byte,
	input  logic              data_taken,
	input  logic [7:0]        buff_din,
	output logic [7:0]        sector_reg,
	output logic [IMG_AW-1:0] buff_addr,
	output logic              buff_rd,
	output logic [7:0]        xfer_byte,
	output logic              xfer_active,
	output logic              drq,
	output logic              read_busy,
	output logic              read_done,
	output logic              err_rnf,
	output logic              err_lost
);

	typedef enum logic [2:0] {
		S_IDLE, S_SEARCH, S_FETCH, S_LOAD, S_DRQ, S_GAP, S_DONE
	} rd_state_t;

	rd_state_t         state;
	logic [9:0]        tmr;      // shared by search, drq and gap waits
	logic [9:0]        byte_idx;
	logic              multi;
	logic              rnf;
	logic [2:0]        geom;
	logic [7:0]        spt;
	logic [1:0]        code;
	logic [10:0]       sec_size;
	logic [IMG_AW-1:0] lin_sector;
	logic              sec_bad;
	logic              last_byte;

	// ==================================================
	// geometry and image address
	// ==================================================

	assign geom     = (size_code > 3'd5) ? 3'd0 : size_code;
	assign spt      = GEOM_SPT[geom];
	assign code     = GEOM_SIZE_CODE[geom];
	assign sec_size = 11'd128 << code;

	// sectors are numbered from 1
	assign lin_sector = IMG_AW'({disk_track, side}) * IMG_AW'(spt)
		+ IMG_AW'(sector_reg) - IMG_AW'(1);
	assign buff_addr  = (lin_sector << (code + 4'd7)) + IMG_AW'(byte_idx);

	assign sec_bad   = (sector_reg == 8'd0) || (sector_reg > spt) || !drive_ready;
	assign last_byte = ({1'b0, byte_idx} == sec_size - 11'd1);

	assign buff_rd     = (state == S_FETCH);
	assign drq         = (state == S_DRQ);
	assign xfer_active = state inside {S_FETCH, S_LOAD, S_DRQ, S_GAP};
	assign read_busy   = (state != S_IDLE);
	assign read_done   = (state == S_DONE);
	assign err_rnf     = read_done && rnf;
	assign err_lost    = drq && !data_taken && (tmr == 10'd0); // byte skipped

	// ==================================================
	// control FSM
	// ==================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			tmr        <= 10'd0;
			byte_idx   <= 10'd0;
			multi      <= 1'b0;
			rnf        <= 1'b0;
			sector_reg <= 8'd1;
		end else if (cmd_valid && cmd_kind == CMD_ABORT) begin
			state <= S_IDLE;
		end else begin
			if (sector_wr)
				sector_reg <= wr_byte;
			case (state)
				S_IDLE: if (cmd_valid && cmd_kind == CMD_READ) begin
					multi <= cmd_flag_u;
					rnf   <= 1'b0;
					tmr   <= 10'(SEARCH_CYCLES) - 10'd1;
					state <= S_SEARCH;
				end
				S_SEARCH: if (tmr != 10'd0) begin
					tmr <= tmr - 10'd1;
				end else if (sec_bad) begin
					rnf   <= 1'b1; // also covers drive not ready
					state <= S_DONE;
				end else begin
					byte_idx <= 10'd0;
					state    <= S_FETCH;
				end
				S_FETCH: state <= S_LOAD; // RAM answers next cycle
				S_LOAD: begin
					tmr   <= LOST_CYCLES - 10'd1;
					state <= S_DRQ;
				end
				S_DRQ: if (data_taken || tmr == 10'd0) begin
					tmr   <= 10'(BYTE_GAP_CYCLES) - 10'd1;
					state <= S_GAP;
				end else begin
					tmr <= tmr - 10'd1;
				end
				S_GAP: if (tmr != 10'd0) begin
					tmr <= tmr - 10'd1;
				end else if (!last_byte) begin
					byte_idx <= byte_idx + 10'd1;
					state    <= S_FETCH;
				end else if (multi) begin
					sector_reg <= sector_reg + 8'd1; // ends with rnf past spt
					tmr        <= 10'(SEARCH_CYCLES) - 10'd1;
					state      <= S_SEARCH;
				end else begin
					state <= S_DONE;
				end
				default: state <= S_IDLE; // S_DONE
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == S_LOAD)
			xfer_byte <= buff_din;
	end

endmodule

// File: fdc_status.sv
/*
 * result stage
 * merges execute busy flags, latches error bits, builds the status
 * byte and drives the interrupt request
 */
`timescale 1ns/1ns

module fdc_status import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       cmd_valid,
	input  cmd_kind_t  cmd_kind,
	input  logic       cmd_hld,
	input  logic       seek_busy,
	input  logic       read_busy,
	input  logic       seek_done,
	input  logic       read_done,
	input  logic       err_rnf,
	input  logic       err_lost,
	input  logic       drq,
	input  logic       drive_ready,
	input  logic [7:0] disk_track,
	input  logic       status_taken,
	output logic       busy,
	output logic       intrq,
	output logic [7:0] status_byte
);

	logic cmd_mode;    // 0 type I, 1 type II
	logic head_loaded;
	logic seek_err;
	logic lost_data;
	logic track0;
	logic abort;

	assign busy   = seek_busy | read_busy;
	assign track0 = (disk_track == 8'd0);
	assign abort  = cmd_valid && (cmd_kind == CMD_ABORT);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cmd_mode    <= 1'b0;
			head_loaded <= 1'b0;
			seek_err    <= 1'b0;
			lost_data   <= 1'b0;
			intrq       <= 1'b0;
		end else begin
			if (cmd_valid) begin
				case (cmd_kind)
					CMD_NONE: ;
					CMD_READ: begin
						cmd_mode  <= 1'b1;
						seek_err  <= 1'b0;
						lost_data <= 1'b0;
					end
					CMD_ABORT: begin
						cmd_mode  <= 1'b0;
						seek_err  <= 1'b0;
						lost_data <= 1'b0;
					end
					default: begin // positioning
						cmd_mode    <= 1'b0;
						head_loaded <= cmd_hld;
						seek_err    <= 1'b0;
					end
				endcase
			end
			if (err_rnf)
				seek_err <= 1'b1;
			if (err_lost)
				lost_data <= 1'b1;
			if (seek_done || read_done || abort) // set wins over clear
				intrq <= 1'b1;
			else if (status_taken || cmd_valid)
				intrq <= 1'b0;
		end
	end

	// write protect, crc and index bits stay 0
	assign status_byte = cmd_mode ?
		{~drive_ready, 1'b0, 1'b0, seek_err, 1'b0, lost_data, drq, busy} :
		{~drive_ready, 1'b0, head_loaded, seek_err, 1'b0, track0, 1'b0, busy};

endmodule

// File: fdc_top.sv
/*
 * floppy disk controller top level
 * WD179x style register set over a byte image RAM
 */
`timescale 1ns/1ns

module fdc_top import fdc_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              rd,
	input  logic              wr,
	input  logic [1:0]        addr,
	input  logic [7:0]        din,
	output logic [7:0]        dout,
	output logic              drq,
	output logic              intrq,
	output logic              busy,
	input  logic [2:0]        size_code,
	input  logic              side,
	input  logic              drive_ready,
	output logic [IMG_AW-1:0] buff_addr,
	output logic              buff_rd,
	input  logic [7:0]        buff_din
);

	logic       cmd_valid;
	cmd_kind_t  cmd_kind;
	logic       cmd_flag_u;
	logic       cmd_hld;
	logic       cmd_dir;
	logic       track_wr;
	logic       sector_wr;
	logic [7:0] wr_byte;
	logic [7:0] data_reg;
	logic       data_taken;
	logic       status_taken;
	logic [7:0] status_byte;
	logic [7:0] track_reg;
	logic [7:0] sector_reg;
	logic [7:0] disk_track;
	logic [7:0] xfer_byte;
	logic       xfer_active;
	logic       seek_busy;
	logic       seek_done;
	logic       read_busy;
	logic       read_done;
	logic       err_rnf;
	logic       err_lost;

	fdc_cmd_decode u_decode (
		.clk_sys(clk_sys), .rst_n(rst_n), .rd(rd), .wr(wr), .addr(addr), .din(din),
		.busy(busy), .status_byte(status_byte), .track_reg(track_reg),
		.sector_reg(sector_reg), .xfer_byte(xfer_byte), .xfer_active(xfer_active),
		.dout(dout), .cmd_valid(cmd_valid), .cmd_kind(cmd_kind), .cmd_flag_u(cmd_flag_u),
		.cmd_hld(cmd_hld), .cmd_dir(cmd_dir), .track_wr(track_wr), .sector_wr(sector_wr),
		.wr_byte(wr_byte), .data_reg(data_reg), .data_taken(data_taken),
		.status_taken(status_taken)
	);

	fdc_head_ctrl u_head (
		.clk_sys(clk_sys), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_kind(cmd_kind),
		.cmd_flag_u(cmd_flag_u), .cmd_dir(cmd_dir), .data_reg(data_reg),
		.track_wr(track_wr), .wr_byte(wr_byte), .disk_track(disk_track),
		.track_reg(track_reg), .seek_busy(seek_busy), .seek_done(seek_done)
	);

	fdc_sector_read u_read (
		.clk_sys(clk_sys), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_kind(cmd_kind),
		.cmd_flag_u(cmd_flag_u), .disk_track(disk_track), .side(side),
		.size_code(size_code), .drive_ready(drive_ready), .sector_wr(sector_wr),
		.wr_byte(wr_byte), .data_taken(data_taken), .buff_din(buff_din),
		.sector_reg(sector_reg), .buff_addr(buff_addr), .buff_rd(buff_rd),
		.xfer_byte(xfer_byte), .xfer_active(xfer_active), .drq(drq),
		.read_busy(read_busy), .read_done(read_done), .err_rnf(err_rnf),
		.err_lost(err_lost)
	);

	fdc_status u_status (
		.clk_sys(clk_sys), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_kind(cmd_kind),
		.cmd_hld(cmd_hld), .seek_busy(seek_busy), .read_busy(read_busy),
		.seek_done(seek_done), .read_done(read_done), .err_rnf(err_rnf),
		.err_lost(err_lost), .drq(drq), .drive_ready(drive_ready),
		.disk_track(disk_track), .status_taken(status_taken), .busy(busy),
		.intrq(intrq), .status_byte(status_byte)
	);

endmodule

// File: fdc_checker.sv
/*
 * handshake assertions on the controller top level
 * bound into fdc_top
 */
`timescale 1ns/1ns

module fdc_checker (
	input logic clk_sys,
	input logic rst_n,
	input logic drq,
	input logic busy,
	input logic buff_rd,
	input logic intrq
);

	// a byte is only offered inside a command
	a_drq_busy: assert property (@(posedge clk_sys) disable iff (!rst_n)
		drq |-> busy) else $error("drq high while the controller is idle");

	a_buff_busy: assert property (@(posedge clk_sys) disable iff (!rst_n)
		buff_rd |-> busy) else $error("image read while the controller is idle");

	// intrq comes up together with the end of busy
	a_intrq_end: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(intrq) |-> !busy) else $error("intrq raised while still busy");

endmodule

bind fdc_top fdc_checker u_chk (
	.clk_sys(clk_sys), .rst_n(rst_n), .drq(drq), .busy(busy),
	.buff_rd(buff_rd), .intrq(intrq)
);

// File: tb_fdc.sv
/*
 * floppy disk controller testbench
 * random register, positioning and sector read traffic against a
 * reference model of the head and the disk image
 */
`timescale 1ns/1ns

module tb_fdc import fdc_pkg::*; ();

	logic        clk_sys;
	logic        rst_n;
	logic        rd;
	logic        wr;
	logic [1:0]  addr;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        drq;
	logic        intrq;
	logic        busy;
	logic [2:0]  size_code;
	logic        side;
	logic        drive_ready;
	logic [19:0] buff_addr;
	logic        buff_rd;
	logic [7:0]  buff_din;

	logic [7:0] img [0:(1<<20)-1]; // disk image RAM
	integer     seed;
	int         errors;
	int         tests;
	int         failed_tests;
	int         test_start_errs;
	bit         saw_drq;

	// reference model state
	logic [7:0] m_track;
	logic [7:0] m_treg;
	logic       m_dir;   // 1 = out

	int spt_tab [0:5]  = '{26, 16, 9, 5, 10, 18};
	int code_tab [0:5] = '{0, 1, 2, 3, 2, 1};

	fdc_top dut0 (
		.clk_sys(clk_sys), .rst_n(rst_n), .rd(rd), .wr(wr), .addr(addr), .din(din),
		.dout(dout), .drq(drq), .intrq(intrq), .busy(busy), .size_code(size_code),
		.side(side), .drive_ready(drive_ready), .buff_addr(buff_addr),
		.buff_rd(buff_rd), .buff_din(buff_din)
	);

	always #10 clk_sys = ~clk_sys;

	// image RAM answers on the next edge
	always @(negedge clk_sys) begin
		if (buff_rd)
			buff_din <= img[buff_addr];
	end

	// ==================================================
	// helpers
	// ==================================================

	function automatic int pick(input int lo, input int hi);
		int unsigned r;
		int unsigned span;
		r = $unsigned($random(seed));
		span = $unsigned(hi - lo + 1);
		return lo + int'(r % span);
	endfunction

	// image offset of one byte of a sector
	function automatic logic [19:0] img_addr(input int trk, input int sd, input int geo,
			input int sec, input int idx);
		int lin;
		lin = (trk * 2 + sd) * spt_tab[geo] + sec - 1;
		return 20'((lin << (7 + code_tab[geo])) + idx);
	endfunction

	task automatic value_fail(input string what, input logic [7:0] got,
			input logic [7:0] exp);
		$display("Fail at %0t: %s, got %02h expected %02h", $time, what, got, exp);
		errors++;
	endtask

	task automatic flag_fail(input string what);
		$display("Fail at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start_errs) begin
			$display("test %0d %s: pass", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - test_start_errs);
		end
		test_start_errs = errors;
	endtask

	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		addr = a;
		din  = d;
		wr   = 1'b1;
		@(negedge clk_sys);
		wr = 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
		@(negedge clk_sys);
		addr = a;
		rd   = 1'b1;
		#2 d = dout; // mid low phase
		@(negedge clk_sys);
		rd = 1'b0;
	endtask

	task automatic wait_drq(output bit ok);
		int n;
		n = 0;
		while (!drq && n < 4000) begin
			@(negedge clk_sys);
			n++;
		end
		ok = drq;
		if (!ok) begin
			$display("timeout: drq never came, gave up at %0t", $time);
			errors++;
		end
	endtask

	task automatic wait_intrq(output bit ok);
		int n;
		n = 0;
		saw_drq = 1'b0;
		while (!intrq && n < 4000) begin
			@(negedge clk_sys);
			if (drq)
				saw_drq = 1'b1;
			n++;
		end
		ok = intrq;
		if (!ok) begin
			$display("timeout: command never raised intrq, gave up at %0t", $time);
			errors++;
		end
	endtask

	task automatic status_check(input logic [7:0] mask, input logic [7:0] exp,
			input string what);
		logic [7:0] st;
		bus_read(A_STATUS, st);
		if ((st & mask) !== exp)
			value_fail(what, st & mask, exp);
	endtask

	// kind 0 restore, 1 seek, 2 step, 3 step in, 4 step out
	task automatic run_pos(input int kind, input bit hld, input bit upd,
			input logic [7:0] target);
		logic [7:0] cmd;
		logic [7:0] tr;
		bit         ok;
		case (kind)
			0: cmd = 8'h00;
			1: cmd = 8'h10;
			2: cmd = 8'h20;
			3: cmd = 8'h40;
			default: cmd = 8'h60;
		endcase
		cmd = cmd | {4'b0, hld, 3'b0};
		if (kind >= 2)
			cmd = cmd | {3'b0, upd, 4'b0};
		if (kind == 0) begin
			m_track = 8'd0;
			m_treg  = 8'd0;
		end else if (kind == 1) begin
			bus_write(A_DATA, target); // seek target
			m_track = target;
			m_treg  = target;
		end else begin
			if (kind == 3)
				m_dir = 1'b0;
			else if (kind == 4)
				m_dir = 1'b1;
			if (m_dir)
				m_track = (m_track == 8'd0) ? 8'd0 : m_track - 8'd1;
			else
				m_track = m_track + 8'd1;
			if (upd)
				m_treg = m_track;
		end
		bus_write(A_COMMAND, cmd);
		if (!busy)
			flag_fail("busy low after a positioning command");
		wait_intrq(ok);
		if (ok && busy)
			flag_fail("busy still high with intrq set");
		status_check(8'hB5, {2'b00, hld, 2'b00, (m_track == 8'd0), 2'b00},
			"type I status");
		if (intrq)
			flag_fail("intrq not cleared by the status read");
		bus_read(A_TRACK, tr);
		if (tr !== m_treg)
			value_fail("track register", tr, m_treg);
	endtask

	task automatic read_sector(input int trk, input int sd, input int geo, input int sec,
			output bit ok);
		int         idx;
		logic [7:0] b;
		logic [7:0] exp_b;
		ok = 1'b1;
		for (idx = 0; idx < (128 << code_tab[geo]); idx++) begin
			wait_drq(ok);
			if (!ok)
				break;
			bus_read(A_DATA, b);
			exp_b = img[img_addr(trk, sd, geo, sec, idx)];
			if (b !== exp_b)
				value_fail("sector byte", b, exp_b);
		end
	endtask

	// read that must end in an error with no byte offered
	task automatic read_error(input logic [7:0] sec, input logic [7:0] exp_st,
			input string what);
		bit ok;
		bus_write(A_SECTOR, sec);
		bus_write(A_COMMAND, 8'h80);
		wait_intrq(ok);
		if (saw_drq)
			flag_fail("drq during a failing read");
		status_check(8'h97, exp_st, what);
	endtask

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		int         i;
		int         n;
		int         geo;
		int         sd;
		int         sec;
		int         start;
		bit         ok;
		bit         lost;
		logic [7:0] v;
		logic [7:0] v1;
		logic [7:0] v2;
		logic [7:0] st;

		seed = 32'h4af0_c160;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		test_start_errs = 0;
		clk_sys = 1'b0;
		rst_n = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = 2'd0;
		din = 8'd0;
		size_code = 3'd0;
		side = 1'b0;
		drive_ready = 1'b1;
		buff_din = 8'd0;
		m_track = 8'd0;
		m_treg = 8'd0;
		m_dir = 1'b0;
		for (i = 0; i < (1 << 20); i++)
			img[i] = 8'($random(seed));
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		// registers, idle and busy
		if (busy || drq || intrq || buff_rd)
			flag_fail("outputs not idle after reset");
		bus_read(A_TRACK, v);
		if (v !== 8'd0)
			value_fail("track after reset", v, 8'd0);
		bus_read(A_SECTOR, v);
		if (v !== 8'd1)
			value_fail("sector after reset", v, 8'd1);
		v1 = 8'(pick(0, 255));
		bus_write(A_TRACK, v1);
		bus_read(A_TRACK, v);
		if (v !== v1)
			value_fail("track readback", v, v1);
		v2 = 8'(pick(0, 255));
		bus_write(A_SECTOR, v2);
		bus_read(A_SECTOR, v);
		if (v !== v2)
			value_fail("sector readback", v, v2);
		bus_write(A_COMMAND, 8'h00); // restore
		bus_write(A_TRACK, ~v1);
		bus_write(A_SECTOR, ~v2);
		bus_write(A_COMMAND, 8'h50); // step in while busy is dropped
		wait_intrq(ok);
		bus_read(A_TRACK, v);
		if (v !== 8'd0)
			value_fail("track after restore", v, 8'd0);
		bus_read(A_SECTOR, v);
		if (v !== v2)
			value_fail("sector written while busy", v, v2);
		status_check(8'h05, 8'h04, "track 0 after restore");
		end_test("register access");

		// positioning
		for (n = 0; n < 16; n++)
			run_pos(pick(0, 4), pick(0, 1) == 1, pick(0, 1) == 1, 8'(pick(0, 79)));
		end_test("positioning");

		// single sector reads
		for (n = 0; n < 3; n++) begin
			geo = pick(0, 5);
			sd = pick(0, 1);
			run_pos(1, 1'b1, 1'b0, 8'(pick(0, 79)));
			@(negedge clk_sys);
			size_code = 3'(geo);
			side = sd[0];
			sec = pick(1, spt_tab[geo]);
			bus_write(A_SECTOR, 8'(sec));
			bus_write(A_COMMAND, 8'h80);
			read_sector(int'(m_track), sd, geo, sec, ok);
			if (ok)
				wait_intrq(ok);
			status_check(8'h97, 8'h00, "status after single read");
		end
		end_test("single sector read");

		// multi sector read to the end of the track
		geo = pick(0, 5);
		sd = pick(0, 1);
		run_pos(1, 1'b0, 1'b0, 8'(pick(0, 79)));
		@(negedge clk_sys);
		size_code = 3'(geo);
		side = sd[0];
		start = spt_tab[geo] - pick(0, 2);
		bus_write(A_SECTOR, 8'(start));
		bus_write(A_COMMAND, 8'h90);
		ok = 1'b1;
		for (sec = start; sec <= spt_tab[geo] && ok; sec++)
			read_sector(int'(m_track), sd, geo, sec, ok);
		if (ok) begin
			wait_intrq(ok);
			if (saw_drq)
				flag_fail("drq after the last sector");
		end
		status_check(8'h97, 8'h10, "status after multi read");
		bus_read(A_SECTOR, v);
		if (v !== 8'(spt_tab[geo] + 1))
			value_fail("sector after multi read", v, 8'(spt_tab[geo] + 1));
		end_test("multi sector read");

		// record not found and drive not ready
		geo = pick(0, 5);
		@(negedge clk_sys);
		size_code = 3'(geo);
		read_error(8'd0, 8'h10, "sector 0");
		read_error(8'(spt_tab[geo] + 1), 8'h10, "sector past spt");
		@(negedge clk_sys);
		drive_ready = 1'b0;
		read_error(8'd1, 8'h90, "drive not ready");
		@(negedge clk_sys);
		drive_ready = 1'b1;
		end_test("read errors");

		// lost data, then force interrupt
		bus_write(A_SECTOR, 8'd1);
		bus_write(A_COMMAND, 8'h80);
		wait_drq(ok);
		n = 0;
		lost = 1'b0;
		while (ok && !lost && n < 1000) begin
			bus_read(A_STATUS, st);
			lost = st[2];
			n++;
		end
		if (!lost) begin
			$display("timeout: lost data bit never set, gave up at %0t", $time);
			errors++;
		end
		if (!busy)
			flag_fail("busy dropped before the force interrupt");
		bus_write(A_COMMAND, 8'hD0);
		if (busy || drq || !intrq)
			flag_fail("force interrupt did not stop the read");
		end_test("lost data and abort");

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: src.f
fdc_pkg.sv
fdc_cmd_decode.sv
fdc_head_ctrl.sv
fdc_sector_read.sv
fdc_status.sv
fdc_top.sv
fdc_checker.sv
tb_fdc.sv

// File: run_sim.sh
#!/bin/sh
# build and run the floppy controller testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_fdc -f src.f
# the log decides pass or fail
./obj_dir/Vtb_fdc > sim.log 2>&1 || true
cat sim.log
if grep -qx "Test OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
